//--- design/sfpp_io_params.svh
/* SFP+ cage management parameters
   Port count, bus widths, register map and link qualifier timing */

`ifndef SFPP_IO_PARAMS_SVH
`define SFPP_IO_PARAMS_SVH

// ----------------------------------------------------------------------
// Bus geometry
// ----------------------------------------------------------------------
`define SFPP_NUM_PORTS   4        // Cages on the bus
`define SFPP_AWIDTH      14       // Byte address width
`define SFPP_DWIDTH      32       // Register data width

// ----------------------------------------------------------------------
// Register map, offsets inside one port window
// ----------------------------------------------------------------------
`define SFPP_REG_MAC     4'h0     // MAC control
`define SFPP_REG_PHY     4'h4     // PHY control and status
`define SFPP_REG_LCNT    4'h8     // Link-up event count
`define SFPP_REG_ID      4'hC     // Port identity

// Port index starts here, 16 byte windows
`define SFPP_PORT_SHIFT  4

// Link qualifier hold time in bus_clk cycles
`define SFPP_LINK_HOLD   16

// Tag in the upper half of PORT_ID
`define SFPP_ID_TAG      16'h5F10

`endif

//--- design/sfpp_io_pkg.sv
/* SFP+ cage management types
   Register select and link state enums, port request/response structs */

`include "sfpp_io_params.svh"

package sfpp_io_pkg;

   // ----------------------------------------------------------------------
   // Enums
   // ----------------------------------------------------------------------

   // One value per register in a port window
   typedef enum logic [1:0] {
      SEL_MAC  = 2'd0,   // MAC control
      SEL_PHY  = 2'd1,   // PHY control/status
      SEL_LCNT = 2'd2,   // Link event counter
      SEL_ID   = 2'd3    // Port identity
   } reg_sel_e;

   // Link qualifier states
   typedef enum logic [1:0] {
      LINK_DOWN = 2'd0,  // No signal or PHY held in reset
      LINK_WAIT = 2'd1,  // Signal present, holding off
      LINK_UP   = 2'd2   // Qualified
   } link_state_e;

   // ----------------------------------------------------------------------
   // Structs
   // ----------------------------------------------------------------------

   // Request routed to one port core
   typedef struct packed {
      logic                    wr;    // Write strobe
      logic                    rd;    // Read strobe
      reg_sel_e                sel;   // Target register
      logic [`SFPP_DWIDTH-1:0] data;  // Write data
   } port_req_t;

   // Read response from one port core
   typedef struct packed {
      logic                    valid; // One cycle pulse
      logic [`SFPP_DWIDTH-1:0] data;
   } port_rsp_t;

   // Cage status in bus_clk
   typedef struct packed {
      logic los;       // Loss of signal, synchronized
      logic fault;     // Transmit fault, synchronized
      logic link_up;   // Qualified link
      logic up_event;  // Pulse on each link-up
   } link_stat_t;

endpackage

//--- design/sfpp_reg_fanout.sv
/* Register request fan-out
   Registers the bus strobes, decodes port and register, routes one request */

`include "sfpp_io_params.svh"

module sfpp_reg_fanout (
   input  logic                       bus_clk,
   input  logic                       bus_rst,
   input  logic                       wr_req_i,
   input  logic [`SFPP_AWIDTH-1:0]    wr_addr_i,
   input  logic [`SFPP_DWIDTH-1:0]    wr_data_i,
   input  logic                       rd_req_i,
   input  logic [`SFPP_AWIDTH-1:0]    rd_addr_i,
   output sfpp_io_pkg::port_req_t     port_req_o [`SFPP_NUM_PORTS]
);
   localparam int AW     = `SFPP_AWIDTH;
   localparam int PSHIFT = `SFPP_PORT_SHIFT;
   localparam int PIDX_W = $clog2(`SFPP_NUM_PORTS);

   // Bus input stage
   logic                       wr_req_q, rd_req_q;
   logic [AW-1:0]              wr_addr_q, rd_addr_q;
   logic [`SFPP_DWIDTH-1:0]    wr_data_q;

   // Decoded request
   logic                       wr_hit, rd_hit;
   sfpp_io_pkg::reg_sel_e      wr_sel, rd_sel;

   // Hit when inside the port range and on a known offset
   function automatic logic addr_decode(input logic [AW-1:0] addr,
                                        output sfpp_io_pkg::reg_sel_e sel);
      logic hit;
      hit = (addr[AW-1:PSHIFT+PIDX_W] == '0);  // Above 0x3F is unmapped
      sel = sfpp_io_pkg::SEL_MAC;
      case (addr[PSHIFT-1:0])
         `SFPP_REG_MAC:  sel = sfpp_io_pkg::SEL_MAC;
         `SFPP_REG_PHY:  sel = sfpp_io_pkg::SEL_PHY;
         `SFPP_REG_LCNT: sel = sfpp_io_pkg::SEL_LCNT;
         `SFPP_REG_ID:   sel = sfpp_io_pkg::SEL_ID;
         default:        hit = 1'b0;            // Misaligned offset
      endcase
      return hit;
   endfunction

   always_ff @(posedge bus_clk) begin
      wr_addr_q <= wr_addr_i;
      wr_data_q <= wr_data_i;
      rd_addr_q <= rd_addr_i;
      if (bus_rst) begin
         wr_req_q <= 1'b0;
         rd_req_q <= 1'b0;
      end else begin
         wr_req_q <= wr_req_i;
         rd_req_q <= rd_req_i;
      end
   end

   always_comb begin
      wr_hit = wr_req_q & addr_decode(wr_addr_q, wr_sel);
      rd_hit = rd_req_q & addr_decode(rd_addr_q, rd_sel);
   end

   // ----------------------------------------------------------------------
   // Per-port request register
   // ----------------------------------------------------------------------
   always_ff @(posedge bus_clk) begin
      for (int p = 0; p < `SFPP_NUM_PORTS; p++) begin
         // Write select wins when both land on this port
         if (wr_hit && wr_addr_q[PSHIFT +: PIDX_W] == PIDX_W'(p))
            port_req_o[p].sel <= wr_sel;
         else
            port_req_o[p].sel <= rd_sel;
         port_req_o[p].data <= wr_data_q;
         if (bus_rst) begin
            port_req_o[p].wr <= 1'b0;
            port_req_o[p].rd <= 1'b0;
         end else begin
            port_req_o[p].wr <= wr_hit && (wr_addr_q[PSHIFT +: PIDX_W] == PIDX_W'(p));
            port_req_o[p].rd <= rd_hit && (rd_addr_q[PSHIFT +: PIDX_W] == PIDX_W'(p));
         end
      end
   end

endmodule

//--- design/sfpp_link_monitor.sv
/* SFP+ cage link monitor
   Synchronizes LOS and TX fault pins, qualifies link-up with a hold timer */

`include "sfpp_io_params.svh"

module sfpp_link_monitor (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  logic                     phy_rst_i,    // PHY held in reset
   input  logic                     rxlos_i,      // Cage pin, async
   input  logic                     tx_fault_i,   // Cage pin, async
   output sfpp_io_pkg::link_stat_t  stat_o
);
   localparam int HOLD  = `SFPP_LINK_HOLD;
   localparam int CNT_W = $clog2(`SFPP_LINK_HOLD + 1);

   // ----------------------------------------------------------------------
   // Pin synchronizers
   // ----------------------------------------------------------------------
   logic [1:0] los_sync;    // [1] is the stable stage
   logic [1:0] fault_sync;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         los_sync   <= 2'b11;   // Treat as no signal until sampled
         fault_sync <= 2'b00;
      end else begin
         los_sync   <= {los_sync[0], rxlos_i};
         fault_sync <= {fault_sync[0], tx_fault_i};
      end
   end

   // ----------------------------------------------------------------------
   // Link qualifier FSM
   // ----------------------------------------------------------------------
   sfpp_io_pkg::link_state_e state;
   logic [CNT_W-1:0]         hold_cnt;
   logic                     up_event;
   logic                     sig_ok;

   // Signal present and PHY out of reset
   assign sig_ok = ~los_sync[1] & ~phy_rst_i;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state    <= sfpp_io_pkg::LINK_DOWN;
         hold_cnt <= '0;
         up_event <= 1'b0;
      end else begin
         up_event <= 1'b0;
         if (!sig_ok) begin
            state    <= sfpp_io_pkg::LINK_DOWN;  // Drop from any state
            hold_cnt <= '0;
         end else begin
            case (state)
               sfpp_io_pkg::LINK_DOWN: begin
                  state    <= sfpp_io_pkg::LINK_WAIT;
                  hold_cnt <= CNT_W'(1);   // First cycle of hold
               end
               sfpp_io_pkg::LINK_WAIT: begin
                  if (hold_cnt == CNT_W'(HOLD - 1)) begin
                     state    <= sfpp_io_pkg::LINK_UP;
                     up_event <= 1'b1;     // Entry pulse
                  end else begin
                     hold_cnt <= hold_cnt + 1'b1;
                  end
               end
               sfpp_io_pkg::LINK_UP: ;     // Stay while signal holds
               default: state <= sfpp_io_pkg::LINK_DOWN;
            endcase
         end
      end
   end

   // Status out
   assign stat_o.los      = los_sync[1];
   assign stat_o.fault    = fault_sync[1];
   assign stat_o.link_up  = (state == sfpp_io_pkg::LINK_UP);
   assign stat_o.up_event = up_event;

endmodule

//--- design/sfpp_port_core.sv
/* SFP+ port core
   MAC/PHY control, sticky fault flags, link-up counter and register readback */

`include "sfpp_io_params.svh"

module sfpp_port_core #(
   parameter int PORT_NUM = 0       // Port index reported in PORT_ID
)(
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  sfpp_io_pkg::port_req_t   req_i,
   input  sfpp_io_pkg::link_stat_t  stat_i,
   output logic                     phy_rst_o,
   output logic                     tx_disable_o,
   output sfpp_io_pkg::port_rsp_t   rsp_o
);
   localparam int         DW      = `SFPP_DWIDTH;
   localparam logic [7:0] PORT_ID = 8'(PORT_NUM);

   // ----------------------------------------------------------------------
   // Control registers
   // ----------------------------------------------------------------------
   logic [DW-1:0] mac_ctrl;     // [0] tx enable, [1] forced disable
   logic          phy_rst;      // PHY control bit 0
   logic          los_seen;     // Sticky, PHY bit 8
   logic          fault_seen;   // Sticky, PHY bit 9
   logic [15:0]   link_cnt;     // Link-up events
   logic          wr_mac, wr_phy;

   assign wr_mac = req_i.wr && (req_i.sel == sfpp_io_pkg::SEL_MAC);
   assign wr_phy = req_i.wr && (req_i.sel == sfpp_io_pkg::SEL_PHY);

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         mac_ctrl <= DW'(1);       // Transmit enabled out of reset
         phy_rst  <= 1'b0;
      end else begin
         if (wr_mac)
            mac_ctrl <= req_i.data;
         if (wr_phy)
            phy_rst  <= req_i.data[0];
      end
   end

   // Sticky flags, set beats write-one-to-clear
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         los_seen   <= 1'b0;
         fault_seen <= 1'b0;
      end else begin
         los_seen   <= stat_i.los   | (los_seen   & ~(wr_phy & req_i.data[8]));
         fault_seen <= stat_i.fault | (fault_seen & ~(wr_phy & req_i.data[9]));
      end
   end

   // Link-up event counter, wraps
   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         link_cnt <= '0;
      else if (stat_i.up_event)
         link_cnt <= link_cnt + 1'b1;
   end

   // ----------------------------------------------------------------------
   // Cage control
   // ----------------------------------------------------------------------
   assign phy_rst_o    = phy_rst;
   assign tx_disable_o = ~mac_ctrl[0]     // Transmit not enabled
                       | mac_ctrl[1]      // Forced off
                       | phy_rst
                       | stat_i.fault;    // Module reports fault

   // ----------------------------------------------------------------------
   // Readback
   // ----------------------------------------------------------------------
   logic [DW-1:0] phy_status;
   logic [DW-1:0] rd_mux;

   assign phy_status = {22'h0,
                        fault_seen,       // [9]
                        los_seen,         // [8]
                        3'b000,
                        phy_rst,          // [4]
                        1'b0,
                        stat_i.fault,     // [2]
                        stat_i.los,       // [1]
                        stat_i.link_up};  // [0]

   always_comb begin
      case (req_i.sel)
         sfpp_io_pkg::SEL_MAC:  rd_mux = mac_ctrl;
         sfpp_io_pkg::SEL_PHY:  rd_mux = phy_status;
         sfpp_io_pkg::SEL_LCNT: rd_mux = {16'h0, link_cnt};
         sfpp_io_pkg::SEL_ID:   rd_mux = {`SFPP_ID_TAG, 8'h00, PORT_ID};
         default:               rd_mux = '0;
      endcase
   end

   // One cycle response per read strobe
   always_ff @(posedge bus_clk) begin
      rsp_o.data <= rd_mux;
      if (bus_rst)
         rsp_o.valid <= 1'b0;
      else
         rsp_o.valid <= req_i.rd;
   end

endmodule

//--- design/sfpp_rsp_merge.sv
/* Read response merge
   Folds the one-hot port responses into the registered bus read response */

`include "sfpp_io_params.svh"

module sfpp_rsp_merge (
   input  logic                      bus_clk,
   input  logic                      bus_rst,
   input  sfpp_io_pkg::port_rsp_t    rsp_i [`SFPP_NUM_PORTS],
   output logic                      rd_resp_o,
   output logic [`SFPP_DWIDTH-1:0]   rd_data_o
);
   localparam int DW = `SFPP_DWIDTH;

   logic          any_valid;   // At most one port responds
   logic [DW-1:0] merged;

   // ----------------------------------------------------------------------
   // One-hot OR mux
   // ----------------------------------------------------------------------
   always_comb begin
      any_valid = 1'b0;
      merged    = '0;
      for (int p = 0; p < `SFPP_NUM_PORTS; p++) begin
         any_valid = any_valid | rsp_i[p].valid;
         merged    = merged | (rsp_i[p].data & {DW{rsp_i[p].valid}});
      end
   end

   // Bus response register
   always_ff @(posedge bus_clk) begin
      rd_data_o <= merged;   // Held until next response
      if (bus_rst)
         rd_resp_o <= 1'b0;
      else
         rd_resp_o <= any_valid;
   end

endmodule

//--- design/sfpp_io_top.sv
/* Four-port SFP+ cage management top
   Register fan-out, per-port link monitor and port core, response merge */

`include "sfpp_io_params.svh"

module sfpp_io_top (
   input  logic                         bus_clk,
   input  logic                         bus_rst,
   // Register bus
   input  logic                         reg_wr_req_i,
   input  logic [`SFPP_AWIDTH-1:0]      reg_wr_addr_i,
   input  logic [`SFPP_DWIDTH-1:0]      reg_wr_data_i,
   input  logic                         reg_rd_req_i,
   input  logic [`SFPP_AWIDTH-1:0]      reg_rd_addr_i,
   output logic                         reg_rd_resp_o,
   output logic [`SFPP_DWIDTH-1:0]      reg_rd_data_o,
   // Cage low-speed pins
   input  logic [`SFPP_NUM_PORTS-1:0]   sfpp_rxlos_i,
   input  logic [`SFPP_NUM_PORTS-1:0]   sfpp_tx_fault_i,
   output logic [`SFPP_NUM_PORTS-1:0]   sfpp_tx_disable_o
);

   sfpp_io_pkg::port_req_t port_req [`SFPP_NUM_PORTS];
   sfpp_io_pkg::port_rsp_t port_rsp [`SFPP_NUM_PORTS];

   // ----------------------------------------------------------------------
   // Request decode
   // ----------------------------------------------------------------------
   sfpp_reg_fanout i_sfpp_reg_fanout (
      .bus_clk    (bus_clk),
      .bus_rst    (bus_rst),
      .wr_req_i   (reg_wr_req_i),
      .wr_addr_i  (reg_wr_addr_i),
      .wr_data_i  (reg_wr_data_i),
      .rd_req_i   (reg_rd_req_i),
      .rd_addr_i  (reg_rd_addr_i),
      .port_req_o (port_req)
   );

   // ----------------------------------------------------------------------
   // Per-cage logic
   // ----------------------------------------------------------------------
   for (genvar g = 0; g < `SFPP_NUM_PORTS; g++) begin : g_port
      sfpp_io_pkg::link_stat_t link_stat;
      logic                    phy_rst;    // Core to monitor

      sfpp_link_monitor i_sfpp_link_monitor (
         .bus_clk    (bus_clk),
         .bus_rst    (bus_rst),
         .phy_rst_i  (phy_rst),
         .rxlos_i    (sfpp_rxlos_i[g]),
         .tx_fault_i (sfpp_tx_fault_i[g]),
         .stat_o     (link_stat)
      );

      sfpp_port_core #(.PORT_NUM(g)) i_sfpp_port_core (
         .bus_clk      (bus_clk),
         .bus_rst      (bus_rst),
         .req_i        (port_req[g]),
         .stat_i       (link_stat),
         .phy_rst_o    (phy_rst),
         .tx_disable_o (sfpp_tx_disable_o[g]),
         .rsp_o        (port_rsp[g])
      );
   end

   // Read response back to the bus
   sfpp_rsp_merge i_sfpp_rsp_merge (
      .bus_clk   (bus_clk),
      .bus_rst   (bus_rst),
      .rsp_i     (port_rsp),
      .rd_resp_o (reg_rd_resp_o),
      .rd_data_o (reg_rd_data_o)
   );

endmodule

//--- bench/sfpp_io_tb.sv
/* SFP+ cage management testbench
   Drives the register bus and cage pins, checks readback and tx_disable */

`include "sfpp_io_params.svh"

module sfpp_io_tb;
   localparam int NP             = `SFPP_NUM_PORTS;
   localparam int DW             = `SFPP_DWIDTH;
   localparam int AW             = `SFPP_AWIDTH;
   localparam int HOLD_WAIT      = `SFPP_LINK_HOLD + 6;  // Sync, hold and count update
   localparam int TIMEOUT_CYCLES = 4000;                 // Tests need under 400 cycles

   logic            bus_clk = 1'b0;
   logic            bus_rst;
   logic            reg_wr_req, reg_rd_req;
   logic [AW-1:0]   reg_wr_addr, reg_rd_addr;
   logic [DW-1:0]   reg_wr_data;
   logic            reg_rd_resp;
   logic [DW-1:0]   reg_rd_data;
   logic [NP-1:0]   sfpp_rxlos, sfpp_tx_fault, sfpp_tx_disable;

   int              cycles = 0;
   int              errors, checks, test_errs, tests_done;
   string           test_name;
   logic [31:0]     lcg_state;
   logic [DW-1:0]   mac_shadow [NP];    // Last MAC control written per port
   logic [NP-1:0]   prst_shadow;        // PHY reset bit per port

   sfpp_io_top i_sfpp_io_top (
      .bus_clk           (bus_clk),
      .bus_rst           (bus_rst),
      .reg_wr_req_i      (reg_wr_req),
      .reg_wr_addr_i     (reg_wr_addr),
      .reg_wr_data_i     (reg_wr_data),
      .reg_rd_req_i      (reg_rd_req),
      .reg_rd_addr_i     (reg_rd_addr),
      .reg_rd_resp_o     (reg_rd_resp),
      .reg_rd_data_o     (reg_rd_data),
      .sfpp_rxlos_i      (sfpp_rxlos),
      .sfpp_tx_fault_i   (sfpp_tx_fault),
      .sfpp_tx_disable_o (sfpp_tx_disable)
   );

   initial forever #50 bus_clk = ~bus_clk;   // Period 100

   // Run limit
   always @(posedge bus_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // Reference rules
   // ----------------------------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // PHY register layout
   function automatic logic [DW-1:0] phy_word(input logic link, input logic los,
                                              input logic fault, input logic prst,
                                              input logic los_s, input logic fault_s);
      logic [DW-1:0] w;
      w    = '0;
      w[0] = link;
      w[1] = los;
      w[2] = fault;
      w[4] = prst;
      w[8] = los_s;
      w[9] = fault_s;
      return w;
   endfunction

   function automatic logic tx_off(input logic [DW-1:0] mac, input logic prst,
                                   input logic fault);
      return ~mac[0] | mac[1] | prst | fault;   // Any reason to keep the laser off
   endfunction

   function automatic logic [AW-1:0] reg_addr(input int port, input logic [3:0] off);
      return AW'(port << `SFPP_PORT_SHIFT) | AW'(off);
   endfunction

   // ----------------------------------------------------------------------
   // Checks and bus tasks, all entered on a falling edge
   // ----------------------------------------------------------------------
   task automatic check_eq(input string what, input logic [DW-1:0] exp,
                           input logic [DW-1:0] act);
      checks++;
      assert (act === exp) else begin
         $display("ERR %s %s: expected %08h, actual %08h", test_name, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge bus_clk);
   endtask

   task automatic bus_write(input int port, input logic [3:0] off, input logic [DW-1:0] data);
      reg_wr_req  = 1'b1;
      reg_wr_addr = reg_addr(port, off);
      reg_wr_data = data;
      @(negedge bus_clk);
      reg_wr_req  = 1'b0;
   endtask

   // Response must come exactly 3 cycles after the request edge
   task automatic bus_read_check(input int port, input logic [3:0] off,
                                 input logic [DW-1:0] exp, input string what);
      reg_rd_req  = 1'b1;
      reg_rd_addr = reg_addr(port, off);
      @(negedge bus_clk);
      reg_rd_req  = 1'b0;
      wait_cycles(2);
      check_eq($sformatf("%s p%0d early resp", what, port), '0, DW'(reg_rd_resp));
      @(negedge bus_clk);
      check_eq($sformatf("%s p%0d resp", what, port), DW'(1), DW'(reg_rd_resp));
      check_eq($sformatf("%s p%0d", what, port), exp, reg_rd_data);
   endtask

   task automatic unmapped_read(input logic [AW-1:0] addr);
      reg_rd_req  = 1'b1;
      reg_rd_addr = addr;
      @(negedge bus_clk);
      reg_rd_req  = 1'b0;
      for (int i = 0; i < 5; i++) begin
         check_eq($sformatf("unmapped %04h resp", addr), '0, DW'(reg_rd_resp));
         @(negedge bus_clk);
      end
   endtask

   task automatic check_tx_disable();
      for (int p = 0; p < NP; p++)
         check_eq($sformatf("tx_disable[%0d]", p),
                  DW'(tx_off(mac_shadow[p], prst_shadow[p], sfpp_tx_fault[p])),
                  DW'(sfpp_tx_disable[p]));
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_done++;
      $display("%s done, %0d errors", test_name, test_errs);
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0]   rnd;
      logic [DW-1:0] val;
      bus_rst       = 1'b1;
      reg_wr_req    = 1'b0;
      reg_wr_addr   = '0;
      reg_wr_data   = '0;
      reg_rd_req    = 1'b0;
      reg_rd_addr   = '0;
      sfpp_rxlos    = '1;          // Cages start with no signal
      sfpp_tx_fault = '0;
      lcg_state     = 32'h5f87;
      errors        = 0;
      checks        = 0;
      tests_done    = 0;
      prst_shadow   = '0;
      for (int p = 0; p < NP; p++)
         mac_shadow[p] = DW'(1);
      wait_cycles(8);
      bus_rst = 1'b0;
      wait_cycles(2);

      // LOS pin high, so LOS and its sticky flag read set
      start_test("reset_state");
      for (int p = 0; p < NP; p++) begin
         bus_read_check(p, `SFPP_REG_MAC, DW'(1), "mac");
         bus_read_check(p, `SFPP_REG_PHY, phy_word(0, 1, 0, 0, 1, 0), "phy");
         bus_read_check(p, `SFPP_REG_LCNT, '0, "lcnt");
      end
      check_eq("tx_disable", '0, DW'(sfpp_tx_disable));
      end_test();

      start_test("control_writes");
      for (int r = 0; r < 3; r++) begin
         for (int p = 0; p < NP; p++) begin
            rnd = lcg_next();
            val = {rnd[15:0], rnd[31:16]};   // Upper LCG bits into the control bits
            bus_write(p, `SFPP_REG_MAC, val);
            mac_shadow[p] = val;
            wait_cycles(2);
            check_tx_disable();
            bus_read_check(p, `SFPP_REG_MAC, val, "mac");
         end
      end
      for (int p = 0; p < NP; p++) begin
         bus_write(p, `SFPP_REG_MAC, DW'(1));
         mac_shadow[p] = DW'(1);
      end
      wait_cycles(2);
      check_tx_disable();
      end_test();

      start_test("port_id");
      for (int p = 0; p < NP; p++)
         bus_read_check(p, `SFPP_REG_ID, {`SFPP_ID_TAG, 8'h00, 8'(p)}, "id");
      unmapped_read(AW'('h040));
      unmapped_read(AW'('h2A0C));
      end_test();

      // Port 1 only
      start_test("link_qualify");
      sfpp_rxlos[1] = 1'b0;
      wait_cycles(HOLD_WAIT);
      bus_write(1, `SFPP_REG_PHY, DW'('h100));    // Clear old LOS flag
      bus_read_check(1, `SFPP_REG_PHY, phy_word(1, 0, 0, 0, 0, 0), "phy up");
      bus_read_check(1, `SFPP_REG_LCNT, DW'(1), "lcnt");
      sfpp_rxlos[1] = 1'b1;
      wait_cycles(4);
      bus_read_check(1, `SFPP_REG_PHY, phy_word(0, 1, 0, 0, 1, 0), "phy down");
      sfpp_rxlos[1] = 1'b0;
      wait_cycles(HOLD_WAIT);
      bus_read_check(1, `SFPP_REG_LCNT, DW'(2), "lcnt again");
      bus_read_check(1, `SFPP_REG_PHY, phy_word(1, 0, 0, 0, 1, 0), "phy up again");
      for (int p = 0; p < NP; p++) begin
         if (p != 1) begin
            bus_read_check(p, `SFPP_REG_LCNT, '0, "other lcnt");
            bus_read_check(p, `SFPP_REG_PHY, phy_word(0, 1, 0, 0, 1, 0), "other phy");
         end
      end
      check_tx_disable();
      end_test();

      // Port 2, fault pulse then PHY reset
      start_test("fault_phy_reset");
      sfpp_tx_fault[2] = 1'b1;
      wait_cycles(4);
      check_eq("tx_disable in fault", DW'(1), DW'(sfpp_tx_disable[2]));
      wait_cycles(1);
      sfpp_tx_fault[2] = 1'b0;
      wait_cycles(4);
      check_tx_disable();
      bus_read_check(2, `SFPP_REG_PHY, phy_word(0, 1, 0, 0, 1, 1), "phy fault seen");
      bus_write(2, `SFPP_REG_PHY, DW'('h200));
      bus_read_check(2, `SFPP_REG_PHY, phy_word(0, 1, 0, 0, 1, 0), "phy fault clear");
      bus_write(2, `SFPP_REG_PHY, DW'(1));
      prst_shadow[2] = 1'b1;
      sfpp_rxlos[2]  = 1'b0;                    // Signal present, reset holds link
      wait_cycles(HOLD_WAIT);
      check_tx_disable();
      bus_read_check(2, `SFPP_REG_PHY, phy_word(0, 0, 0, 1, 1, 0), "phy in reset");
      bus_read_check(2, `SFPP_REG_LCNT, '0, "lcnt in reset");
      bus_write(2, `SFPP_REG_PHY, DW'('h100));  // Release, clear LOS flag
      prst_shadow[2] = 1'b0;
      wait_cycles(HOLD_WAIT);
      check_tx_disable();
      bus_read_check(2, `SFPP_REG_PHY, phy_word(1, 0, 0, 0, 0, 0), "phy released");
      bus_read_check(2, `SFPP_REG_LCNT, DW'(1), "lcnt released");
      end_test();

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- sfpp_io.f
+incdir+design
design/sfpp_io_pkg.sv
design/sfpp_reg_fanout.sv
design/sfpp_link_monitor.sv
design/sfpp_port_core.sv
design/sfpp_rsp_merge.sv
design/sfpp_io_top.sv
bench/sfpp_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the SFP+ cage management testbench with Verilator and run it.
# Exit status is 0 only when the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module sfpp_io_tb \
   -f sfpp_io.f -o sfpp_io_sim || { echo "Verilator build error"; exit 1; }

out=$(./obj_dir/sfpp_io_sim)
echo "$out"

echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
